/* filelist.f */
+incdir+tests
hdl/synth_pkg.sv
hdl/voice_bus_if.sv
hdl/voice_regs.sv
hdl/frame_timer.sv
hdl/voice_osc.sv
hdl/mix_pan.sv
hdl/dac_serializer.sv
hdl/synth_top.sv
tests/tb_clk_gen.sv
tests/synth_tb.sv

/* Bender.yml */
package:
  name: synth_voice

sources:
  - files:
      - hdl/synth_pkg.sv
      - hdl/voice_bus_if.sv
      - hdl/voice_regs.sv
      - hdl/frame_timer.sv
      - hdl/voice_osc.sv
      - hdl/mix_pan.sv
      - hdl/dac_serializer.sv
      - hdl/synth_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_clk_gen.sv
      - tests/synth_tb.sv

/* tests/synth_model.svh */
`ifndef SYNTH_MODEL_SVH
`define SYNTH_MODEL_SVH

// Expected left and right of one frame, phases advanced in place
function automatic logic [2*synth_pkg::SAMPLE_W-1:0] model_frame(
    input logic [synth_pkg::N_VOICES-1:0][synth_pkg::PHASE_W-1:0] steps,
    input synth_pkg::voice_ctrl_t [synth_pkg::N_VOICES-1:0]       ctrls,
    input logic [synth_pkg::BAL_W-1:0]                            bal,
    inout logic [synth_pkg::N_VOICES-1:0][synth_pkg::PHASE_W-1:0] phases
);
    longint wave;
    longint mix;
    longint left;
    longint right;
    mix = 0;
    for (int v = 0; v < synth_pkg::N_VOICES; v++) begin
        if (ctrls[v].enable) begin
            if (ctrls[v].shape == synth_pkg::SHAPE_SQUARE) begin
                wave = phases[v][synth_pkg::PHASE_W-1] ? -synth_pkg::MAX_AMP : synth_pkg::MAX_AMP;
            end else begin
                wave = longint'(phases[v]) - longint'(1 << 23);  // Ramp centred on zero
            end
            mix = mix + ((wave * longint'(ctrls[v].velocity)) >>> synth_pkg::VEL_SHIFT);
            phases[v] = phases[v] + steps[v];                      // Wraps at 24 bits
        end
    end
    right = (mix * longint'(bal)) >>> 8;
    left  = (mix * (255 - longint'(bal))) >>> 8;
    return {left[synth_pkg::SAMPLE_W-1:0], right[synth_pkg::SAMPLE_W-1:0]};
endfunction

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end else begin
        return state >> 1;
    end
endfunction

task automatic check_sample(input string name, input synth_pkg::sample_t got,
                            input synth_pkg::sample_t exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

`endif

/* tests/synth_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module synth_tb;

    logic                           sys_clk;
    logic                           rst;
    logic                           wr_en;
    logic [synth_pkg::ADDR_W-1:0]   wr_addr;
    logic [synth_pkg::SAMPLE_W-1:0] wr_data;
    logic                           dac_bclk;
    logic                           dac_lrclk;
    logic                           dac_data;

    // Mirror of the registers and phases
    logic [synth_pkg::N_VOICES-1:0][synth_pkg::PHASE_W-1:0] m_step;
    logic [synth_pkg::N_VOICES-1:0][synth_pkg::PHASE_W-1:0] m_phase;
    synth_pkg::voice_ctrl_t [synth_pkg::N_VOICES-1:0]       m_ctrl;
    logic [synth_pkg::BAL_W-1:0]                            m_bal;
    logic [2*synth_pkg::SAMPLE_W-1:0]                       exp_q [$];  // Pending expected pairs

    synth_pkg::sample_t rx_l;
    synth_pkg::sample_t rx_r;
    synth_pkg::sample_t last_left;   // Most recent pair off the line
    synth_pkg::sample_t last_right;
    int                 nbits;
    int                 rx_count;    // LR falls seen
    int                 rise_count;  // LR rises seen
    logic               bclk_q;
    logic               lr_q;
    logic [31:0]        lfsr;
    int                 err_count;
    int                 check_count;
    int                 test_count;

    tb_clk_gen u_clk (.o_clk(sys_clk));

    synth_top DUT (
        .sys_clk(sys_clk), .i_rst(rst), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
        .i_wr_data(wr_data), .o_dac_bclk(dac_bclk), .o_dac_lrclk(dac_lrclk),
        .o_dac_data(dac_data)
    );

    `include "synth_model.svh"

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic [synth_pkg::SAMPLE_W-1:0] make_ctrl(
        input logic en, input synth_pkg::shape_e shape, input logic [synth_pkg::VEL_W-1:0] vel);
        synth_pkg::voice_ctrl_t c;
        c.enable   = en;
        c.shape    = shape;
        c.unused   = '0;
        c.velocity = vel;
        return c;
    endfunction

    // One write strobe with the mirror decoded by the address map
    task automatic write_reg(input logic [synth_pkg::ADDR_W-1:0] addr,
                             input logic [synth_pkg::SAMPLE_W-1:0] data);
        @(posedge sys_clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        if (addr < 2 * synth_pkg::N_VOICES) begin
            if (addr[0]) m_ctrl[addr[2:1]] = synth_pkg::voice_ctrl_t'(data);
            else         m_step[addr[2:1]] = data;
        end else if (addr == synth_pkg::BAL_ADDR) begin
            m_bal = data[synth_pkg::BAL_W-1:0];
        end
        @(posedge sys_clk);
        wr_en <= 1'b0;
    endtask

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};      // One step per bit
        end
    endtask

    // Wait for the mid-frame point where writes are safe
    task automatic wait_lr_rise();
        int start;
        int cycles;
        start  = rise_count;
        cycles = 0;
        while (rise_count == start && cycles < 2 * synth_pkg::FRAME_CYCLES) begin
            @(posedge sys_clk);
            cycles++;
        end
        if (rise_count == start) abort_run("LR clock did not rise within two frames");
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = rx_count + n;
        cycles = 0;
        while (rx_count < target && cycles < (n + 2) * synth_pkg::FRAME_CYCLES) begin
            @(posedge sys_clk);
            cycles++;
        end
        if (rx_count < target) abort_run("received fewer frames than expected");
    endtask

    // Check the finished pair and queue the model of the new frame
    task automatic compare_pair();
        logic [2*synth_pkg::SAMPLE_W-1:0] e;
        if (nbits != 2 * synth_pkg::SAMPLE_W) begin
            err_count++;
            $display("frame %0d carried %0d bits instead of 48", rx_count, nbits);
        end
        e = exp_q.pop_front();
        check_sample("left sample", rx_l, e[2*synth_pkg::SAMPLE_W-1:synth_pkg::SAMPLE_W]);
        check_sample("right sample", rx_r, e[synth_pkg::SAMPLE_W-1:0]);
        last_left  = rx_l;
        last_right = rx_r;
        exp_q.push_back(model_frame(m_step, m_ctrl, m_bal, m_phase));
        rx_count++;
        nbits = 0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        test_count++;
        $display("test %0d %s: %s", num, name, (err_count == errs_before) ? "pass" : "fail");
    endtask

    // Deserializer watching the DAC lines at mid-cycle
    always @(negedge sys_clk) begin
        if (rst) begin
            nbits  = 0;
            bclk_q = 1'b0;
            lr_q   = 1'b0;
        end else begin
            if (dac_bclk && !bclk_q) begin
                if (dac_lrclk) rx_r = {rx_r[synth_pkg::SAMPLE_W-2:0], dac_data};
                else           rx_l = {rx_l[synth_pkg::SAMPLE_W-2:0], dac_data};
                nbits++;
            end
            if (dac_lrclk && !lr_q) rise_count++;
            if (!dac_lrclk && lr_q) compare_pair();
            bclk_q = dac_bclk;
            lr_q   = dac_lrclk;
        end
    end

    initial begin
        logic [31:0] r_step;
        logic [31:0] r_vel;
        logic [31:0] r_shape;
        int          errs;
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        lfsr    = 32'h63e2aa4e;
        m_step  = '0;
        m_phase = '0;
        m_ctrl  = '0;
        m_bal   = synth_pkg::BAL_RESET[synth_pkg::BAL_W-1:0];
        exp_q.push_back('0);           // Reset hold pair
        exp_q.push_back('0);           // First frame with all voices off

        errs = err_count;
        repeat (7) @(posedge sys_clk);
        @(negedge sys_clk);
        check_level("o_dac_bclk", dac_bclk, 1'b0);
        check_level("o_dac_lrclk", dac_lrclk, 1'b0);
        check_level("o_dac_data", dac_data, 1'b0);
        @(posedge sys_clk);
        rst <= 1'b0;                   // Eighth edge ends reset
        wait_frames(3);
        report_test(1, "reset silence", errs);

        errs = err_count;
        wait_lr_rise();
        write_reg(4'd0, 24'h300000);   // Wraps within eight frames
        write_reg(4'd1, make_ctrl(1'b1, synth_pkg::SHAPE_SAW, 16'hffff));
        wait_frames(10);
        report_test(2, "saw voice", errs);

        errs = err_count;
        wait_lr_rise();
        write_reg(4'd1, make_ctrl(1'b0, synth_pkg::SHAPE_SAW, 16'hffff));
        write_reg(4'd2, 24'h123456);
        write_reg(4'd3, make_ctrl(1'b1, synth_pkg::SHAPE_SQUARE, 16'h8000));
        write_reg(4'd4, 24'h0a0000);
        write_reg(4'd5, make_ctrl(1'b0, synth_pkg::SHAPE_SAW, 16'hc000));  // Voice 2 parked
        wait_frames(6);
        wait_lr_rise();
        write_reg(4'd5, make_ctrl(1'b1, synth_pkg::SHAPE_SAW, 16'hc000));
        wait_frames(6);
        report_test(3, "square with disabled voice", errs);

        errs = err_count;
        wait_lr_rise();
        for (int v = 0; v < synth_pkg::N_VOICES; v++) begin
            draw_bits(synth_pkg::PHASE_W, r_step);
            draw_bits(synth_pkg::VEL_W, r_vel);
            draw_bits(1, r_shape);
            write_reg(4'(2 * v), r_step[synth_pkg::PHASE_W-1:0]);
            write_reg(4'(2 * v + 1), make_ctrl(1'b1, synth_pkg::shape_e'(r_shape[0]),
                                               r_vel[synth_pkg::VEL_W-1:0]));
        end
        draw_bits(synth_pkg::BAL_W, r_step);
        write_reg(4'(synth_pkg::BAL_ADDR), {16'h0, r_step[synth_pkg::BAL_W-1:0]});
        wait_frames(18);
        report_test(4, "random four voices", errs);

        errs = err_count;
        wait_lr_rise();
        write_reg(4'(synth_pkg::BAL_ADDR), 24'h0);
        wait_frames(4);
        check_sample("right sample at balance 0", last_right, '0);
        wait_lr_rise();
        write_reg(4'(synth_pkg::BAL_ADDR), 24'hff);
        wait_frames(4);
        check_sample("left sample at balance 255", last_left, '0);
        report_test(5, "balance extremes", errs);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock, 20 ns period
module tb_clk_gen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #10 o_clk = ~o_clk;  // Half period

endmodule

`default_nettype wire

/* hdl/synth_top.sv */
`timescale 1ns/1ns
`default_nettype none

module synth_top (
    input  wire logic                           sys_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_wr_en,
    input  wire logic [synth_pkg::ADDR_W-1:0]   i_wr_addr,
    input  wire logic [synth_pkg::SAMPLE_W-1:0] i_wr_data,
    output      logic                           o_dac_bclk,
    output      logic                           o_dac_lrclk,
    output      logic                           o_dac_data
);

    logic                              frame_start;
    logic                              slot_valid;
    logic [synth_pkg::VOICE_IDX_W-1:0] slot_idx;
    logic                              bclk_fall;
    logic                              bclk_rise;
    logic                              sample_valid;
    logic                              sample_last;
    synth_pkg::sample_t                sample;       // One voice per slot
    synth_pkg::sample_t                left;
    synth_pkg::sample_t                right;
    logic                              pair_ready;   // New pair once per frame
    logic [synth_pkg::BAL_W-1:0]       balance;

    voice_bus_if u_bus ();

    voice_regs u_regs (
        .sys_clk(sys_clk), .i_rst(i_rst), .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr),
        .i_wr_data(i_wr_data), .o_balance(balance), .bus(u_bus.regs)
    );

    frame_timer u_timer (
        .sys_clk(sys_clk), .i_rst(i_rst), .o_frame_start(frame_start),
        .o_slot_valid(slot_valid), .o_slot_idx(slot_idx),
        .o_bclk_fall(bclk_fall), .o_bclk_rise(bclk_rise)
    );

    voice_osc u_osc (
        .sys_clk(sys_clk), .i_rst(i_rst), .i_slot_valid(slot_valid), .i_slot_idx(slot_idx),
        .bus(u_bus.osc), .o_sample_valid(sample_valid), .o_sample_last(sample_last),
        .o_sample(sample)
    );

    mix_pan u_mix (
        .sys_clk(sys_clk), .i_rst(i_rst), .i_frame_start(frame_start),
        .i_sample_valid(sample_valid), .i_sample_last(sample_last), .i_sample(sample),
        .i_balance(balance), .o_left(left), .o_right(right), .o_pair_ready(pair_ready)
    );

    dac_serializer u_dac (
        .sys_clk(sys_clk), .i_rst(i_rst), .i_frame_start(frame_start),
        .i_bclk_fall(bclk_fall), .i_bclk_rise(bclk_rise), .i_pair_ready(pair_ready),
        .i_left(left), .i_right(right),
        .o_bclk(o_dac_bclk), .o_lrclk(o_dac_lrclk), .o_data(o_dac_data)
    );

endmodule

`default_nettype wire

/* hdl/dac_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module dac_serializer (
    input  wire logic               sys_clk,
    input  wire logic               i_rst,
    input  wire logic               i_frame_start,
    input  wire logic               i_bclk_fall,
    input  wire logic               i_bclk_rise,
    input  wire logic               i_pair_ready,
    input  wire synth_pkg::sample_t i_left,
    input  wire synth_pkg::sample_t i_right,
    output      logic               o_bclk,
    output      logic               o_lrclk,
    output      logic               o_data
);

    synth_pkg::sample_t                   hold_l;     // Pair waiting for next frame
    synth_pkg::sample_t                   hold_r;
    logic [2*synth_pkg::SAMPLE_W-1:0]     shreg;      // Bit 47 is the bit on the line
    logic [$clog2(2*synth_pkg::SAMPLE_W)-1:0] bit_cnt;    // 0..47 within the frame
    logic [$clog2(2*synth_pkg::SAMPLE_W)-1:0] cnt_nxt;

    assign cnt_nxt = bit_cnt + 1'b1;

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            hold_l  <= '0;
            hold_r  <= '0;
            shreg   <= '0;
            bit_cnt <= '0;
            o_bclk  <= 1'b0;
            o_lrclk <= 1'b0;
            o_data  <= 1'b0;
        end else begin
            if (i_pair_ready) begin
                hold_l <= i_left;
                hold_r <= i_right;
            end
            if (i_bclk_fall) o_bclk <= 1'b0;
            if (i_bclk_rise) o_bclk <= 1'b1;
            if (i_frame_start) begin
                shreg   <= {hold_l, hold_r};           // Left first, MSB first
                o_data  <= hold_l[synth_pkg::SAMPLE_W-1];
                bit_cnt <= '0;
                o_lrclk <= 1'b0;
            end else if (i_bclk_fall) begin
                shreg   <= shreg << 1;
                o_data  <= shreg[2*synth_pkg::SAMPLE_W-2];  // Next bit after a fall
                bit_cnt <= cnt_nxt;
                o_lrclk <= (cnt_nxt >= synth_pkg::SAMPLE_W);  // Right half
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mix_pan.sv */
`timescale 1ns/1ns
`default_nettype none

module mix_pan (
    input  wire logic                         sys_clk,
    input  wire logic                         i_rst,
    input  wire logic                         i_frame_start,
    input  wire logic                         i_sample_valid,
    input  wire logic                         i_sample_last,
    input  wire synth_pkg::sample_t           i_sample,
    input  wire logic [synth_pkg::BAL_W-1:0]  i_balance,
    output      synth_pkg::sample_t           o_left,
    output      synth_pkg::sample_t           o_right,
    output      logic                         o_pair_ready
);

    synth_pkg::sample_t acc;        // Running voice sum
    synth_pkg::sample_t mix;        // Held sum of the frame
    logic               last_d;     // Last voice added last cycle
    logic               mix_d;      // Mix latched last cycle

    logic [synth_pkg::BAL_W-1:0]                          bal_left;  // 255 - balance
    logic signed [synth_pkg::SAMPLE_W+synth_pkg::BAL_W:0] prod_l;
    logic signed [synth_pkg::SAMPLE_W+synth_pkg::BAL_W:0] prod_r;

    assign bal_left = {synth_pkg::BAL_W{1'b1}} - i_balance;

    always_comb begin
        prod_r = mix * $signed({1'b0, i_balance});
        prod_l = mix * $signed({1'b0, bal_left});
    end

    // Accumulator, cleared before the slot samples arrive
    always_ff @(posedge sys_clk) begin
        if (i_frame_start) begin
            acc <= '0;
        end else if (i_sample_valid) begin
            acc <= acc + i_sample;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            last_d       <= 1'b0;
            mix_d        <= 1'b0;
            o_pair_ready <= 1'b0;
            mix          <= '0;
            o_left       <= '0;     // Silence until the first frame
            o_right      <= '0;
        end else begin
            last_d       <= i_sample_valid && i_sample_last;
            mix_d        <= last_d;
            o_pair_ready <= mix_d;
            if (last_d) begin
                mix <= acc;         // All voices summed
            end
            if (mix_d) begin
                // Divide by 256 after weighting
                o_left  <= prod_l[synth_pkg::SAMPLE_W+synth_pkg::BAL_W-1:synth_pkg::BAL_W];
                o_right <= prod_r[synth_pkg::SAMPLE_W+synth_pkg::BAL_W-1:synth_pkg::BAL_W];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/voice_osc.sv */
`timescale 1ns/1ns
`default_nettype none

module voice_osc (
    input  wire logic                               sys_clk,
    input  wire logic                               i_rst,
    input  wire logic                               i_slot_valid,
    input  wire logic [synth_pkg::VOICE_IDX_W-1:0]  i_slot_idx,
    voice_bus_if.osc                                bus,
    output      logic                               o_sample_valid,
    output      logic                               o_sample_last,
    output      synth_pkg::sample_t                 o_sample
);

    logic [synth_pkg::PHASE_W-1:0] phase [synth_pkg::N_VOICES];  // Per-voice phase
    logic [synth_pkg::PHASE_W-1:0] phase_cur;

    synth_pkg::sample_t                          wave;    // Shaped, full scale
    logic signed [synth_pkg::SAMPLE_W+synth_pkg::VEL_W:0] prod;    // Wave times velocity
    logic signed [synth_pkg::SAMPLE_W+synth_pkg::VEL_W:0] scaled;

    assign bus.voice_idx = i_slot_idx;     // Look up the voice of this slot
    assign phase_cur     = phase[i_slot_idx];

    always_comb begin
        if (bus.ctrl.shape == synth_pkg::SHAPE_SQUARE) begin
            // High half of the cycle is negative
            wave = phase_cur[synth_pkg::PHASE_W-1] ? synth_pkg::sample_t'(-synth_pkg::MAX_AMP)
                                                 : synth_pkg::sample_t'(synth_pkg::MAX_AMP);
        end else begin
            // Offset binary to two's complement ramp
            wave = {~phase_cur[synth_pkg::PHASE_W-1], phase_cur[synth_pkg::PHASE_W-2:0]};
        end
        prod   = wave * $signed({1'b0, bus.ctrl.velocity});   // Velocity is unsigned
        scaled = prod >>> synth_pkg::VEL_SHIFT;
    end

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            for (int i = 0; i < synth_pkg::N_VOICES; i++) begin
                phase[i] <= '0;
            end
            o_sample_valid <= 1'b0;
            o_sample_last  <= 1'b0;
        end else begin
            o_sample_valid <= i_slot_valid;
            o_sample_last  <= i_slot_valid && (i_slot_idx == synth_pkg::N_VOICES - 1);
            if (i_slot_valid && bus.ctrl.enable) begin
                phase[i_slot_idx] <= phase_cur + bus.freq;     // Wraps mod 2^24
            end
        end
    end

    // Sample payload, silent for a disabled voice
    always_ff @(posedge sys_clk) begin
        if (i_slot_valid) begin
            o_sample <= bus.ctrl.enable ? scaled[synth_pkg::SAMPLE_W-1:0] : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_timer (
    input  wire logic                               sys_clk,
    input  wire logic                               i_rst,
    output      logic                               o_frame_start,
    output      logic                               o_slot_valid,
    output      logic [synth_pkg::VOICE_IDX_W-1:0]  o_slot_idx,
    output      logic                               o_bclk_fall,
    output      logic                               o_bclk_rise
);

    logic [$clog2(synth_pkg::FRAME_CYCLES)-1:0] count;      // Position in frame
    logic [$clog2(synth_pkg::FRAME_CYCLES)-1:0] count_nxt;

    assign count_nxt = (count == synth_pkg::FRAME_CYCLES - 1) ? '0 : count + 1'b1;

    // Strobes are registered copies of the count decode,
    // so they trail the counter by one cycle
    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            count         <= '0;
            o_frame_start <= 1'b0;
            o_slot_valid  <= 1'b0;
            o_slot_idx    <= '0;
            o_bclk_fall   <= 1'b0;
            o_bclk_rise   <= 1'b0;
        end else begin
            count         <= count_nxt;
            o_frame_start <= (count == 0);
            o_slot_valid  <= (count < synth_pkg::N_VOICES);      // First slots of frame
            o_slot_idx    <= count[synth_pkg::VOICE_IDX_W-1:0];
            // Bit clock edges every half period of sys_clk / 8
            o_bclk_fall   <= (count % (2 * synth_pkg::BCLK_HALF)) == 0;
            o_bclk_rise   <= (count % (2 * synth_pkg::BCLK_HALF)) == synth_pkg::BCLK_HALF;
        end
    end

endmodule

`default_nettype wire

/* hdl/voice_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module voice_regs (
    input  wire logic                          sys_clk,
    input  wire logic                          i_rst,
    input  wire logic                          i_wr_en,
    input  wire logic [synth_pkg::ADDR_W-1:0]  i_wr_addr,
    input  wire logic [synth_pkg::SAMPLE_W-1:0] i_wr_data,
    output      logic [synth_pkg::BAL_W-1:0]   o_balance,
    voice_bus_if.regs                          bus
);

    // Even entry is the step, odd entry the control word
    synth_pkg::voice_word_u words [2*synth_pkg::N_VOICES];

    logic wr_voice;  // Write hits a voice word
    logic wr_bal;    // Write hits the balance

    assign wr_voice = i_wr_en && (i_wr_addr < 2 * synth_pkg::N_VOICES);
    assign wr_bal   = i_wr_en && (i_wr_addr == synth_pkg::BAL_ADDR);

    always_ff @(posedge sys_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2 * synth_pkg::N_VOICES; i++) begin
                words[i] <= '0;                    // Disabled, zero step
            end
            o_balance <= synth_pkg::BAL_RESET[synth_pkg::BAL_W-1:0];
        end else begin
            if (wr_voice) begin
                // Bits 2:1 voice, bit 0 word select
                words[i_wr_addr[synth_pkg::VOICE_IDX_W:0]] <=
                    synth_pkg::voice_word_u'(i_wr_data);
            end
            if (wr_bal) begin
                o_balance <= i_wr_data[synth_pkg::BAL_W-1:0];  // Low byte only
            end
        end
    end

    // Combinational lookup for the oscillator slot
    always_comb begin
        bus.freq = words[{bus.voice_idx, 1'b0}].freq;   // Step view
        bus.ctrl = words[{bus.voice_idx, 1'b1}].ctrl;   // Control view
    end

endmodule

`default_nettype wire

/* hdl/voice_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One voice's settings, looked up by index each slot
interface voice_bus_if;

    logic [synth_pkg::VOICE_IDX_W-1:0] voice_idx;  // Voice being served
    logic [synth_pkg::PHASE_W-1:0]     freq;       // Its phase step
    synth_pkg::voice_ctrl_t            ctrl;       // Enable, shape, velocity

    // Register side answers the index
    modport regs (
        input  voice_idx,
        output freq,
        output ctrl
    );

    // Oscillator side asks with the index
    modport osc (
        output voice_idx,
        input  freq,
        input  ctrl
    );

endinterface

`default_nettype wire

/* hdl/synth_pkg.sv */
`default_nettype none

package synth_pkg;

    // Voice engine sizes
    localparam int N_VOICES    = 4;
    localparam int VOICE_IDX_W = 2;                // Voice select width
    localparam int SAMPLE_W    = 24;               // DAC word width
    localparam int PHASE_W     = 24;               // Accumulator and step width
    localparam int VEL_W       = 16;
    localparam int BAL_W       = 8;
    localparam int ADDR_W      = 4;

    // Frame timing in sys_clk cycles
    localparam int FRAME_CYCLES = 384;             // One stereo sample pair
    localparam int BCLK_HALF    = 4;               // Bit clock is sys_clk / 8

    // Amplitude scaling
    localparam int MAX_AMP   = (1 << 23) - 1;      // Square wave peak
    localparam int VEL_SHIFT = 18;                 // Two bits of headroom for the mix

    // Register map
    localparam int BAL_ADDR  = 8;                  // Below this are voice words
    localparam int BAL_RESET = 128;                // Centre balance

    typedef enum logic {
        SHAPE_SAW    = 1'b0,
        SHAPE_SQUARE = 1'b1
    } shape_e;

    // Control word as written on odd voice addresses
    typedef struct packed {
        logic              enable;
        shape_e            shape;
        logic [5:0]        unused;
        logic [VEL_W-1:0]  velocity;
    } voice_ctrl_t;

    // Same 24 bits seen as step or control, chosen by address bit 0
    typedef union packed {
        logic [PHASE_W-1:0] freq;
        voice_ctrl_t        ctrl;
    } voice_word_u;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire
